/* src/rename_pkg.sv */
/*
 * Register rename shared types
 * Register index widths and the micro-op structs passed in and out of the stage
 */
`default_nettype none

package rename_pkg;

  localparam int AREG_BITS = 5;
  localparam int PREG_BITS = 6;
  localparam int NUM_PREGS = 64;

  // Width of the checkpoint index carried with a renamed micro-op (CP_DEPTH of 4)
  localparam int CP_IDX_BITS = 2;

  typedef logic [AREG_BITS-1:0] areg_t;
  typedef logic [PREG_BITS-1:0] preg_t;

  // rd of zero means no destination, whatever rd_valid says
  typedef struct packed {
    logic  valid;
    areg_t rs1;
    areg_t rs2;
    areg_t rd;
    logic  rd_valid;
    logic  is_branch;
  } arch_uop_t;

  typedef struct packed {
    logic                   valid;
    preg_t                  prs1;
    preg_t                  prs2;
    preg_t                  prd;
    preg_t                  prev_prd;
    logic                   prev_valid;
    logic                   is_branch;
    logic [CP_IDX_BITS-1:0] cp_idx;
  } renamed_uop_t;

  typedef struct packed {
    logic  valid;
    preg_t prev_prd;
    logic  prev_valid;
    logic  is_branch;
  } retire_t;

endpackage

`default_nettype wire

/* src/map_table.sv */
/*
 * Map table
 * Speculative architectural to physical map with lane-ordered reads,
 * one snapshot per checkpoint and restore on misprediction
 */
`timescale 1ns/100ps
`default_nettype none

module map_table import rename_pkg::*; #(
  parameter int RENAME_WIDTH = 2,
  parameter int CP_DEPTH     = 4
) (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic  [RENAME_WIDTH-1:0]             rd_write,
  input  areg_t [RENAME_WIDTH-1:0]             rd_index,
  input  preg_t [RENAME_WIDTH-1:0]             rd_preg,
  input  areg_t [RENAME_WIDTH-1:0]             rs1,
  input  areg_t [RENAME_WIDTH-1:0]             rs2,
  input  logic                                 save,
  input  logic  [$clog2(CP_DEPTH)-1:0]         save_idx,
  input  logic                                 restore,
  input  logic  [$clog2(CP_DEPTH)-1:0]         restore_idx,
  output preg_t [RENAME_WIDTH-1:0]             prs1,
  output preg_t [RENAME_WIDTH-1:0]             prs2,
  output preg_t [RENAME_WIDTH-1:0]             prev_prd
);

  localparam int NUM_AREGS = 2**AREG_BITS;

  preg_t map_q    [NUM_AREGS];
  preg_t map_next [NUM_AREGS];
  preg_t snap_q   [CP_DEPTH][NUM_AREGS];

  // Walk the lanes in order so a later lane sees writes of earlier lanes;
  // map_next ends up as the map after the whole bundle
  always_comb begin
    map_next = map_q;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      prs1[i]     = map_next[rs1[i]];
      prs2[i]     = map_next[rs2[i]];
      prev_prd[i] = map_next[rd_index[i]];
      if (rd_write[i]) begin
        map_next[rd_index[i]] = rd_preg[i];
      end
    end
  end

  // Identity map out of reset, restore wins over the bundle's writes
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < NUM_AREGS; r++) begin
        map_q[r] <= preg_t'(r);
      end
    end else if (restore) begin
      map_q <= snap_q[restore_idx];
    end else begin
      map_q <= map_next;
    end
  end

  // Snapshot holds the state after the branch bundle
  always_ff @(posedge clock) begin
    if (save) begin
      snap_q[save_idx] <= map_next;
    end
  end

endmodule

`default_nettype wire

/* src/free_list.sv */
/*
 * Free list
 * Circular queue of free physical registers, popped in lane order at the head
 * and refilled at the tail on retire, with a saved head per checkpoint
 */
`timescale 1ns/100ps
`default_nettype none

module free_list import rename_pkg::*; #(
  parameter int RENAME_WIDTH = 2,
  parameter int CP_DEPTH     = 4
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic  [RENAME_WIDTH-1:0]     pop,
  input  logic  [RENAME_WIDTH-1:0]     push,
  input  preg_t [RENAME_WIDTH-1:0]     push_preg,
  input  logic                         save,
  input  logic  [$clog2(CP_DEPTH)-1:0] save_idx,
  input  logic                         restore,
  input  logic  [$clog2(CP_DEPTH)-1:0] restore_idx,
  output preg_t [RENAME_WIDTH-1:0]     pop_preg,
  output logic  [PREG_BITS-1:0]        free_count
);

  // Registers above the architectural range start out free
  localparam int FIRST_FREE = 2**AREG_BITS;

  // Occupancy stays below NUM_PREGS since the live map always holds
  // FIRST_FREE registers, so plain wrapping pointers are enough
  typedef logic [PREG_BITS-1:0] ptr_t;

  preg_t fifo_q       [NUM_PREGS];
  ptr_t  saved_head_q [CP_DEPTH];
  ptr_t  push_ptr     [RENAME_WIDTH];
  ptr_t  head_q;
  ptr_t  tail_q;
  ptr_t  head_after_pop;
  ptr_t  tail_after_push;

  always_comb begin
    head_after_pop = head_q;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      pop_preg[i] = fifo_q[head_after_pop];
      if (pop[i]) begin
        head_after_pop = head_after_pop + 1'b1;
      end
    end
  end

  always_comb begin
    tail_after_push = tail_q;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      push_ptr[i] = tail_after_push;
      if (push[i]) begin
        tail_after_push = tail_after_push + 1'b1;
      end
    end
  end

  // Entries left once this cycle's pops are taken
  assign free_count = tail_q - head_after_pop;

  always_ff @(posedge clock) begin
    if (reset) begin
      head_q <= '0;
      tail_q <= ptr_t'(NUM_PREGS - FIRST_FREE);
    end else begin
      // Rewound entries are still in the buffer ahead of the tail
      head_q <= restore ? saved_head_q[restore_idx] : head_after_pop;
      tail_q <= tail_after_push;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < NUM_PREGS - FIRST_FREE; i++) begin
        fifo_q[i] <= preg_t'(FIRST_FREE + i);
      end
    end else begin
      for (int i = 0; i < RENAME_WIDTH; i++) begin
        if (push[i]) begin
          fifo_q[push_ptr[i]] <= push_preg[i];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (save) begin
      saved_head_q[save_idx] <= head_after_pop;
    end
  end

endmodule

`default_nettype wire

/* src/checkpoint_ring.sv */
/*
 * Checkpoint ring
 * Tracks the live branch checkpoints as a head index and a count,
 * taken at rename, released at retire and trimmed on recover
 */
`timescale 1ns/100ps
`default_nettype none

module checkpoint_ring #(
  parameter int RENAME_WIDTH = 2,
  parameter int CP_DEPTH     = 4
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         take,
  input  logic  [RENAME_WIDTH-1:0]     release_req,
  input  logic                         recover,
  input  logic  [$clog2(CP_DEPTH)-1:0] recover_cp,
  output logic  [$clog2(CP_DEPTH)-1:0] take_idx,
  output logic                         full
);

  localparam int CP_BITS = $clog2(CP_DEPTH);

  logic [CP_BITS-1:0] head_q;
  logic [CP_BITS-1:0] distance;
  logic [CP_BITS:0]   count_q;
  logic [CP_BITS:0]   count_base;
  logic [CP_BITS:0]   count_after_take;
  logic [CP_BITS:0]   num_release;

  assign take_idx         = head_q + count_q[CP_BITS-1:0];
  assign count_after_take = count_q + (CP_BITS + 1)'(take);

  // Counts a take still in progress, so a new bundle is not let in
  // on the last free slot
  assign full = count_after_take >= (CP_BITS + 1)'(CP_DEPTH);

  // Modular distance handles a recover point that wrapped past the end
  assign distance = recover_cp - head_q;

  always_comb begin
    num_release = '0;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      if (release_req[i]) begin
        num_release = num_release + 1'b1;
      end
    end
    // Recovered checkpoint stays live, younger ones are dropped
    count_base = recover ? {1'b0, distance} + 1'b1 : count_after_take;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head_q  <= '0;
      count_q <= '0;
    end else begin
      head_q  <= head_q + num_release[CP_BITS-1:0];
      count_q <= count_base - num_release;
    end
  end

endmodule

`default_nettype wire

/* src/rename_stage.sv */
/*
 * Rename stage
 * Latches a bundle, renames it against the map and free list in the next
 * cycle, takes a checkpoint for a branch bundle and registers the result
 */
`timescale 1ns/100ps
`default_nettype none

module rename_stage import rename_pkg::*; #(
  parameter int RENAME_WIDTH = 2,
  parameter int CP_DEPTH     = 4
) (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                in_valid,
  input  arch_uop_t    [RENAME_WIDTH-1:0]     in_uops,
  output logic                                ready,
  output logic                                out_valid,
  output renamed_uop_t [RENAME_WIDTH-1:0]     out_uops,
  input  retire_t      [RENAME_WIDTH-1:0]     retire,
  input  logic                                recover,
  input  logic         [$clog2(CP_DEPTH)-1:0] recover_cp
);

  localparam int CP_BITS = $clog2(CP_DEPTH);

  arch_uop_t    [RENAME_WIDTH-1:0] bundle_q;
  renamed_uop_t [RENAME_WIDTH-1:0] renamed;
  areg_t        [RENAME_WIDTH-1:0] rs1;
  areg_t        [RENAME_WIDTH-1:0] rs2;
  areg_t        [RENAME_WIDTH-1:0] rd;
  preg_t        [RENAME_WIDTH-1:0] prs1;
  preg_t        [RENAME_WIDTH-1:0] prs2;
  preg_t        [RENAME_WIDTH-1:0] prev_prd;
  preg_t        [RENAME_WIDTH-1:0] pop_preg;
  preg_t        [RENAME_WIDTH-1:0] push_preg;
  logic         [RENAME_WIDTH-1:0] do_rename;
  logic         [RENAME_WIDTH-1:0] push;
  logic         [RENAME_WIDTH-1:0] release_req;
  logic         [CP_BITS-1:0]      take_idx;
  logic         [PREG_BITS-1:0]    free_count;
  logic                            bundle_valid_q;
  logic                            go;
  logic                            has_branch;
  logic                            take;
  logic                            cp_full;

  // A recover squashes the latched bundle
  assign go    = bundle_valid_q & ~recover;
  assign take  = go & has_branch;
  assign ready = (free_count >= PREG_BITS'(RENAME_WIDTH)) & ~cp_full;

  always_comb begin
    has_branch = 1'b0;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      rs1[i]         = bundle_q[i].rs1;
      rs2[i]         = bundle_q[i].rs2;
      rd[i]          = bundle_q[i].rd;
      do_rename[i]   = go & bundle_q[i].valid & bundle_q[i].rd_valid & (bundle_q[i].rd != '0);
      push[i]        = retire[i].valid & retire[i].prev_valid;
      push_preg[i]   = retire[i].prev_prd;
      release_req[i] = retire[i].valid & retire[i].is_branch;
      // Last valid lane decides whether this is a branch bundle
      if (bundle_q[i].valid) begin
        has_branch = bundle_q[i].is_branch;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      renamed[i] = '0;
      if (bundle_q[i].valid) begin
        renamed[i].valid     = 1'b1;
        renamed[i].prs1      = prs1[i];
        renamed[i].prs2      = prs2[i];
        renamed[i].is_branch = bundle_q[i].is_branch;
        renamed[i].cp_idx    = has_branch ? CP_IDX_BITS'(take_idx) : '0;
        if (do_rename[i]) begin
          renamed[i].prd        = pop_preg[i];
          renamed[i].prev_prd   = prev_prd[i];
          renamed[i].prev_valid = 1'b1;
        end
      end
    end
  end

  map_table #(.RENAME_WIDTH(RENAME_WIDTH), .CP_DEPTH(CP_DEPTH)) u_map_table (
    .clock, .reset,
    .rd_write    (do_rename),
    .rd_index    (rd),
    .rd_preg     (pop_preg),
    .rs1, .rs2,
    .save        (take),
    .save_idx    (take_idx),
    .restore     (recover),
    .restore_idx (recover_cp),
    .prs1, .prs2, .prev_prd
  );

  free_list #(.RENAME_WIDTH(RENAME_WIDTH), .CP_DEPTH(CP_DEPTH)) u_free_list (
    .clock, .reset,
    .pop         (do_rename),
    .push, .push_preg,
    .save        (take),
    .save_idx    (take_idx),
    .restore     (recover),
    .restore_idx (recover_cp),
    .pop_preg, .free_count
  );

  checkpoint_ring #(.RENAME_WIDTH(RENAME_WIDTH), .CP_DEPTH(CP_DEPTH)) u_checkpoint_ring (
    .clock, .reset, .take, .release_req, .recover, .recover_cp, .take_idx,
    .full (cp_full)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      bundle_valid_q <= 1'b0;
      out_valid      <= 1'b0;
    end else begin
      bundle_valid_q <= in_valid & ready & ~recover;
      out_valid      <= go;
    end
  end

  always_ff @(posedge clock) begin
    if (in_valid & ready) begin
      bundle_q <= in_uops;
    end
    if (go) begin
      out_uops <= renamed;
    end
  end

endmodule

`default_nettype wire

/* src/rename_top.sv */
/*
 * Rename top level
 * Register-rename stage of the integer core with its outside ports
 */
`timescale 1ns/100ps
`default_nettype none

module rename_top import rename_pkg::*; #(
  parameter int RENAME_WIDTH = 2,
  parameter int CP_DEPTH     = 4
) (
  input  logic                                clock,
  input  logic                                reset,

  // Bundle in
  input  logic                                in_valid,
  input  arch_uop_t    [RENAME_WIDTH-1:0]     in_uops,
  output logic                                ready,

  // Renamed bundle out, one cycle after acceptance
  output logic                                out_valid,
  output renamed_uop_t [RENAME_WIDTH-1:0]     out_uops,

  // Retire and misprediction recovery
  input  retire_t      [RENAME_WIDTH-1:0]     retire,
  input  logic                                recover,
  input  logic         [$clog2(CP_DEPTH)-1:0] recover_cp
);

  rename_stage #(
    .RENAME_WIDTH (RENAME_WIDTH),
    .CP_DEPTH     (CP_DEPTH)
  ) u_rename_stage (
    .clock      (clock),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_uops    (in_uops),
    .ready      (ready),
    .out_valid  (out_valid),
    .out_uops   (out_uops),
    .retire     (retire),
    .recover    (recover),
    .recover_cp (recover_cp)
  );

endmodule

`default_nettype wire

/* verif/rename_checker.sv */
/*
 * Rename stage protocol checker
 * Output timing around bundle acceptance, recover and reset
 */
`timescale 1ns/100ps
`default_nettype none

module rename_checker (
  input logic clock,
  input logic reset,
  input logic in_valid,
  input logic ready,
  input logic recover,
  input logic out_valid
);

  logic accepted_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      accepted_q <= 1'b0;
    end else begin
      accepted_q <= in_valid & ready & ~recover;
    end
  end

  // Output one cycle after acceptance unless a recover squashes it
  out_follows_accept: assert property (
    @(posedge clock) disable iff (reset)
    out_valid == $past(accepted_q & ~recover)
  ) else $error("out_valid does not follow an accepted bundle by one cycle");

  no_out_after_recover: assert property (
    @(posedge clock) disable iff (reset)
    recover |=> !out_valid
  ) else $error("out_valid raised right after a recover");

  // Stage comes out of reset idle and ready
  idle_after_reset: assert property (
    @(posedge clock)
    reset |=> (!out_valid && ready)
  ) else $error("out_valid or ready wrong after reset");

endmodule

bind rename_stage rename_checker u_checker (
  .clock     (clock),
  .reset     (reset),
  .in_valid  (in_valid),
  .ready     (ready),
  .recover   (recover),
  .out_valid (out_valid)
);

`default_nettype wire

/* verif/rename_tb.sv */
/*
 * Rename stage testbench
 * Seeded random bundles, retires and recovers, checked cycle by cycle
 * against a reference model of map, free FIFO and checkpoints
 */
`timescale 1ns/100ps
`default_nettype none

module rename_tb import rename_pkg::*; ();

  localparam int RENAME_WIDTH  = 2;
  localparam int CP_DEPTH      = 4;
  localparam int CP_BITS       = $clog2(CP_DEPTH);
  localparam int NUM_AREGS     = 2**AREG_BITS;
  localparam int NUM_CYCLES    = 4000;
  localparam int READY_TIMEOUT = 200;

  typedef struct packed {
    preg_t              prev_prd;
    logic               prev_valid;
    logic               is_branch;
    logic [CP_BITS-1:0] cp_idx;
  } inflight_t;

  logic                            clock;
  logic                            reset;
  logic                            in_valid;
  arch_uop_t    [RENAME_WIDTH-1:0] in_uops;
  logic                            ready;
  logic                            out_valid;
  renamed_uop_t [RENAME_WIDTH-1:0] out_uops;
  retire_t      [RENAME_WIDTH-1:0] retire;
  logic                            recover;
  logic         [CP_BITS-1:0]      recover_cp;

  // Reference model state
  preg_t        model_map  [NUM_AREGS];
  preg_t        saved_map  [CP_DEPTH][NUM_AREGS];
  int           saved_head [CP_DEPTH];
  preg_t        free_fifo  [$];
  inflight_t    inflight_q [$];
  int           free_head;
  int           cp_head;
  int           cp_count;
  int           seed;
  logic                            pending;
  arch_uop_t    [RENAME_WIDTH-1:0] pending_uops;
  logic                            expect_valid;
  renamed_uop_t [RENAME_WIDTH-1:0] expect_uops;

  rename_top #(.RENAME_WIDTH(RENAME_WIDTH), .CP_DEPTH(CP_DEPTH)) dut (
    .clock, .reset, .in_valid, .in_uops, .ready, .out_valid, .out_uops,
    .retire, .recover, .recover_cp
  );

  always #2 clock = ~clock;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("Mismatch at %0t: %s expected 0x%0h, got 0x%0h",
                         $time, name, expected, actual));
    end
  endtask

  function automatic int rand_below(input int n);
    return ($random(seed) & 32'h7fffffff) % n;
  endfunction

  function automatic areg_t pick_reg();
    // Half the picks come from a few registers to force dependences
    if (rand_below(2) == 0) begin
      return areg_t'(rand_below(6));
    end
    return areg_t'(rand_below(NUM_AREGS));
  endfunction

  function automatic bit ready_from_model();
    return (free_fifo.size() - free_head >= RENAME_WIDTH) && (cp_count < CP_DEPTH);
  endfunction

  task automatic init_model();
    for (int r = 0; r < NUM_AREGS; r++) begin
      model_map[r] = preg_t'(r);
    end
    free_fifo.delete();
    for (int p = NUM_AREGS; p < NUM_PREGS; p++) begin
      free_fifo.push_back(preg_t'(p));
    end
    inflight_q.delete();
    free_head = 0;
    cp_head   = 0;
    cp_count  = 0;
  endtask

  task automatic make_bundle();
    int last;
    last = -1;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      in_uops[i].valid     = rand_below(4) != 0;
      in_uops[i].rs1       = pick_reg();
      in_uops[i].rs2       = pick_reg();
      in_uops[i].rd        = pick_reg();
      in_uops[i].rd_valid  = rand_below(4) != 0;
      in_uops[i].is_branch = 1'b0;
      if (in_uops[i].valid) begin
        last = i;
      end
    end
    if (last < 0) begin
      in_uops[0].valid = 1'b1;
      last = 0;
    end
    // A branch may only close the bundle
    if (rand_below(10) < 3) begin
      in_uops[last].is_branch = 1'b1;
    end
  endtask

  task automatic rename_bundle();
    logic      has_branch;
    int        take;
    inflight_t entry;
    has_branch = 1'b0;
    take = (cp_head + cp_count) % CP_DEPTH;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      if (pending_uops[i].valid && pending_uops[i].is_branch) begin
        has_branch = 1'b1;
      end
    end
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      expect_uops[i] = '0;
      if (pending_uops[i].valid) begin
        expect_uops[i].valid     = 1'b1;
        expect_uops[i].prs1      = model_map[pending_uops[i].rs1];
        expect_uops[i].prs2      = model_map[pending_uops[i].rs2];
        expect_uops[i].is_branch = pending_uops[i].is_branch;
        expect_uops[i].cp_idx    = has_branch ? CP_IDX_BITS'(take) : '0;
        if (pending_uops[i].rd_valid && pending_uops[i].rd != '0) begin
          expect_uops[i].prev_prd   = model_map[pending_uops[i].rd];
          expect_uops[i].prev_valid = 1'b1;
          expect_uops[i].prd        = free_fifo[free_head];
          free_head++;
          model_map[pending_uops[i].rd] = expect_uops[i].prd;
        end
        entry.prev_prd   = expect_uops[i].prev_prd;
        entry.prev_valid = expect_uops[i].prev_valid;
        entry.is_branch  = expect_uops[i].is_branch;
        entry.cp_idx     = CP_BITS'(expect_uops[i].cp_idx);
        inflight_q.push_back(entry);
      end
    end
    if (has_branch) begin
      for (int r = 0; r < NUM_AREGS; r++) begin
        saved_map[take][r] = model_map[r];
      end
      saved_head[take] = free_head;
      cp_count++;
    end
    expect_valid = 1'b1;
  endtask

  task automatic restore_model(input int cp);
    int idx;
    idx = -1;
    for (int k = 0; k < inflight_q.size(); k++) begin
      if (inflight_q[k].is_branch && inflight_q[k].cp_idx == CP_BITS'(cp)) begin
        idx = k;
      end
    end
    if (idx < 0) begin
      fail_run("Recover target checkpoint has no branch in flight");
    end
    // Work younger than the recovered branch is discarded
    while (inflight_q.size() > idx + 1) begin
      void'(inflight_q.pop_back());
    end
    for (int r = 0; r < NUM_AREGS; r++) begin
      model_map[r] = saved_map[cp][r];
    end
    free_head = saved_head[cp];
    cp_count  = ((cp - cp_head + CP_DEPTH) % CP_DEPTH) + 1;
  endtask

  task automatic apply_retire();
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      if (retire[i].valid && retire[i].prev_valid) begin
        free_fifo.push_back(retire[i].prev_prd);
      end
      if (retire[i].valid && retire[i].is_branch) begin
        cp_head = (cp_head + 1) % CP_DEPTH;
        cp_count--;
      end
    end
  endtask

  task automatic check_outputs();
    check_value("out_valid", out_valid, expect_valid);
    if (expect_valid) begin
      for (int i = 0; i < RENAME_WIDTH; i++) begin
        check_value($sformatf("out_uops[%0d].valid", i), out_uops[i].valid,
                    expect_uops[i].valid);
        check_value($sformatf("out_uops[%0d].prs1", i), out_uops[i].prs1, expect_uops[i].prs1);
        check_value($sformatf("out_uops[%0d].prs2", i), out_uops[i].prs2, expect_uops[i].prs2);
        check_value($sformatf("out_uops[%0d].prd", i), out_uops[i].prd, expect_uops[i].prd);
        check_value($sformatf("out_uops[%0d].prev_prd", i), out_uops[i].prev_prd,
                    expect_uops[i].prev_prd);
        check_value($sformatf("out_uops[%0d].prev_valid", i), out_uops[i].prev_valid,
                    expect_uops[i].prev_valid);
        check_value($sformatf("out_uops[%0d].is_branch", i), out_uops[i].is_branch,
                    expect_uops[i].is_branch);
        check_value($sformatf("out_uops[%0d].cp_idx", i), out_uops[i].cp_idx,
                    expect_uops[i].cp_idx);
      end
    end
  endtask

  initial begin
    int        target;
    int        n_ret;
    int        limit;
    int        retire_pct;
    int        wait_count;
    bit        do_recover;
    bit        want;
    bit        model_ready;
    inflight_t entry;

    seed         = 32'h3a8bc282;
    clock        = 1'b0;
    reset        = 1'b1;
    in_valid     = 1'b0;
    in_uops      = '0;
    retire       = '0;
    recover      = 1'b0;
    recover_cp   = '0;
    expect_valid = 1'b0;
    pending      = 1'b0;
    wait_count   = 0;
    init_model();

    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      @(negedge clock);
      check_outputs();
      expect_valid = 1'b0;
      // Slow retire phases drain the free list and fill the checkpoints
      retire_pct  = ((cyc / 300) % 2 == 0) ? 70 : 25;
      do_recover  = (cp_count > 0) && (rand_below(20) == 0);
      target      = 0;
      model_ready = 1'b0;
      if (do_recover) begin
        target      = (cp_head + rand_below(cp_count)) % CP_DEPTH;
        model_ready = ready_from_model();
        restore_model(target);
      end

      // Oldest work retires first, never the recovered branch itself
      limit = do_recover ? inflight_q.size() - 1 : inflight_q.size();
      n_ret = (rand_below(100) < retire_pct) ? 1 + rand_below(RENAME_WIDTH) : 0;
      if (n_ret > limit) begin
        n_ret = limit;
      end
      retire = '0;
      for (int i = 0; i < n_ret; i++) begin
        entry               = inflight_q.pop_front();
        retire[i].valid      = 1'b1;
        retire[i].prev_prd   = entry.prev_prd;
        retire[i].prev_valid = entry.prev_valid;
        retire[i].is_branch  = entry.is_branch;
      end

      if (!do_recover) begin
        if (pending) begin
          rename_bundle();
        end
        model_ready = ready_from_model();
      end
      pending = 1'b0;
      apply_retire();

      recover    = do_recover;
      recover_cp = CP_BITS'(target);
      want       = (cyc < NUM_CYCLES - 8) && (rand_below(100) < 80);
      if (want && model_ready) begin
        make_bundle();
        in_valid     = 1'b1;
        pending      = !do_recover;
        pending_uops = in_uops;
        wait_count   = 0;
      end else begin
        in_valid = 1'b0;
        if (want) begin
          wait_count++;
        end
      end
      if (wait_count > READY_TIMEOUT) begin
        fail_run($sformatf("Timeout: ready stayed low for %0d cycles with a bundle waiting",
                           READY_TIMEOUT));
      end
      #1;
      check_value("ready", ready, model_ready);
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
src/rename_pkg.sv
src/map_table.sv
src/free_list.sv
src/checkpoint_ring.sv
src/rename_stage.sv
src/rename_top.sv
verif/rename_checker.sv
verif/rename_tb.sv

/* run.sh */
#!/bin/sh
# Build the rename stage testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module rename_tb -f compile.f; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/Vrename_tb > sim.log 2>&1; then
  cat sim.log
  echo "Simulation exited with an error status"
  exit 1
fi

cat sim.log

if grep -qx '>>> PASS' sim.log; then
  echo "Run passed"
  exit 0
else
  echo "Run failed"
  exit 1
fi
